// ==== verilog/vga_pkg.sv ====
package vga_pkg;

    // Screen row or column counter value
    typedef logic [9:0] coord_t;

    // Palette index produced by the pixel pipes
    typedef logic [7:0] palette_idx_t;

    // Output colour with red in the top byte and blue in the low byte
    typedef logic [23:0] rgb_t;

    // Video RAM word address and data word
    typedef logic [17:0] ram_adr_t;
    typedef logic [15:0] ram_dat_t;  // Two pixels with the low byte first

    // Index in bits 31:24 and colour in bits 23:0
    typedef logic [31:0] palette_update_t;

    // Value 3 is not listed and is decoded as test mode by the top level
    typedef enum logic [1:0] {
        MODE_BITMAP         = 2'd0,
        MODE_BITMAP_DOUBLED = 2'd1,
        MODE_TEST           = 2'd2
    } vga_mode_t;

endpackage

// ==== verilog/vga_sync.sv ====
module vga_sync #(
    parameter vga_pkg::coord_t LAST_VISIBLE_COL = 10'd639,
    parameter vga_pkg::coord_t H_PULSE_START    = 10'd656,
    parameter vga_pkg::coord_t H_PULSE_END      = 10'd751,
    parameter vga_pkg::coord_t LAST_COL         = 10'd799,
    parameter vga_pkg::coord_t LAST_VISIBLE_ROW = 10'd479,
    parameter vga_pkg::coord_t V_PULSE_START    = 10'd490,
    parameter vga_pkg::coord_t V_PULSE_END      = 10'd491,
    parameter vga_pkg::coord_t LAST_ROW         = 10'd524
) (
    input  logic            I_vga_clk,
    input  logic            rst,
    output vga_pkg::coord_t row,
    output vga_pkg::coord_t col,
    output logic            hsync,
    output logic            vsync,
    output logic            visible
);

    vga_pkg::coord_t col_next;
    vga_pkg::coord_t row_next;
    logic            h_pulse;
    logic            v_pulse;
    logic            in_area;

    always_comb begin
        col_next = col + 10'd1;
        row_next = row;
        if (col == LAST_COL) begin
            col_next = '0;
            row_next = (row == LAST_ROW) ? '0 : row + 10'd1;  // Frame wraps after the last line
        end
    end

    // Decoding the next position keeps the registered flags in step with the counters
    assign h_pulse = (col_next >= H_PULSE_START) && (col_next <= H_PULSE_END);
    assign v_pulse = (row_next >= V_PULSE_START) && (row_next <= V_PULSE_END);
    assign in_area = (col_next <= LAST_VISIBLE_COL) && (row_next <= LAST_VISIBLE_ROW);

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            col     <= '0;
            row     <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            visible <= 1'b0;
        end else begin
            col     <= col_next;
            row     <= row_next;
            hsync   <= !h_pulse;  // Sync pulses are active low
            vsync   <= !v_pulse;
            visible <= in_area;
        end
    end

    a_counters_in_range: assert property (
        @(posedge I_vga_clk) disable iff (rst)
        (col <= LAST_COL) && (row <= LAST_ROW)
    ) else $error("vga_sync counter out of range row=%0d col=%0d", row, col);

endmodule

// ==== verilog/vga_pixelpipe_test.sv ====
module vga_pixelpipe_test (
    input  logic                  I_vga_clk,
    input  logic                  rst,
    input  vga_pkg::coord_t       row,
    input  vga_pkg::coord_t       col,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  visible,
    output vga_pkg::palette_idx_t palette_idx,
    output logic                  hsync_out,
    output logic                  vsync_out,
    output logic                  visible_out
);

    vga_pkg::coord_t       pattern;
    vga_pkg::palette_idx_t idx_s1;
    logic                  hsync_s1;
    logic                  vsync_s1;
    logic                  visible_s1;

    // Low nibble of col XOR row moved up gives 16-pixel checker bars
    assign pattern = (col ^ row) << 4;

    always_ff @(posedge I_vga_clk) begin
        idx_s1      <= pattern[7:0];
        palette_idx <= idx_s1;  // Second stage only matches the bitmap pipe latency
    end

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            hsync_s1    <= 1'b1;
            vsync_s1    <= 1'b1;
            visible_s1  <= 1'b0;
            hsync_out   <= 1'b1;
            vsync_out   <= 1'b1;
            visible_out <= 1'b0;
        end else begin
            hsync_s1    <= hsync;
            vsync_s1    <= vsync;
            visible_s1  <= visible;
            hsync_out   <= hsync_s1;
            vsync_out   <= vsync_s1;
            visible_out <= visible_s1;
        end
    end

endmodule

// ==== verilog/vga_pixelpipe_bitmap.sv ====
module vga_pixelpipe_bitmap #(
    parameter vga_pkg::coord_t LAST_VISIBLE_COL = 10'd639
) (
    input  logic                  I_vga_clk,
    input  logic                  rst,
    input  vga_pkg::coord_t       row,
    input  vga_pkg::coord_t       col,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  visible,
    input  vga_pkg::ram_adr_t     base_adr,
    input  logic                  pixel_doubled,
    input  vga_pkg::ram_dat_t     ram_dat,
    output logic                  ram_req,
    output vga_pkg::ram_adr_t     ram_adr,
    output vga_pkg::palette_idx_t palette_idx,
    output logic                  hsync_out,
    output logic                  vsync_out,
    output logic                  visible_out
);

    localparam vga_pkg::ram_adr_t WORDS_PER_LINE     = (LAST_VISIBLE_COL + 1) / 2;
    localparam vga_pkg::ram_adr_t WORDS_PER_LINE_DBL = (LAST_VISIBLE_COL + 1) / 4;

    vga_pkg::coord_t   eff_row;
    vga_pkg::coord_t   eff_col;
    vga_pkg::ram_adr_t words_per_line;
    vga_pkg::ram_adr_t line_adr;
    logic              fetch;
    logic              fetch_s1;
    logic              odd_s1;
    logic              hsync_s1;
    logic              vsync_s1;
    logic              visible_s1;
    logic              odd_s2;
    vga_pkg::ram_dat_t word_s2;

    assign eff_row        = pixel_doubled ? row >> 1 : row;
    assign eff_col        = pixel_doubled ? col >> 1 : col;
    assign words_per_line = pixel_doubled ? WORDS_PER_LINE_DBL : WORDS_PER_LINE;
    assign line_adr       = vga_pkg::ram_adr_t'(eff_row) * words_per_line;

    // One read per word, on the first raw column that shows it
    assign fetch   = visible && !eff_col[0] && !(pixel_doubled && col[0]);
    assign ram_req = fetch;
    assign ram_adr = base_adr + line_adr + vga_pkg::ram_adr_t'(eff_col >> 1);

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            fetch_s1    <= 1'b0;
            hsync_s1    <= 1'b1;
            vsync_s1    <= 1'b1;
            visible_s1  <= 1'b0;
            hsync_out   <= 1'b1;
            vsync_out   <= 1'b1;
            visible_out <= 1'b0;
        end else begin
            fetch_s1    <= fetch;
            hsync_s1    <= hsync;
            vsync_s1    <= vsync;
            visible_s1  <= visible;
            hsync_out   <= hsync_s1;
            vsync_out   <= vsync_s1;
            visible_out <= visible_s1;
        end
    end

    always_ff @(posedge I_vga_clk) begin
        odd_s1 <= eff_col[0];
        odd_s2 <= odd_s1;
        if (fetch_s1) begin
            word_s2 <= ram_dat;  // RAM answers in the cycle after the request
        end
    end

    // Word stays put until the next fetch, so the odd pixel reuses it
    assign palette_idx = odd_s2 ? word_s2[15:8] : word_s2[7:0];

    a_fetch_in_visible: assert property (
        @(posedge I_vga_clk) disable iff (rst)
        ram_req |-> visible
    ) else $error("vga_pixelpipe_bitmap fetch outside the visible area");

endmodule

// ==== verilog/vga_palette.sv ====
module vga_palette (
    input  logic                     I_vga_clk,
    input  logic                     rst,
    input  logic                     update_req,
    input  vga_pkg::palette_update_t update,
    input  vga_pkg::palette_idx_t    palette_idx,
    output logic                     update_ack,
    output vga_pkg::rgb_t            rgb
);

    typedef enum logic {
        PAL_IDLE  = 1'b0,
        PAL_ACKED = 1'b1
    } pal_state_t;

    pal_state_t            state;
    vga_pkg::rgb_t         colour_mem [256];
    vga_pkg::palette_idx_t wr_idx;
    vga_pkg::rgb_t         wr_rgb;
    logic                  wr_en;

    assign wr_idx = update[31:24];
    assign wr_rgb = update[23:0];
    assign wr_en  = (state == PAL_IDLE) && update_req;  // Exactly one write per request

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            state <= PAL_IDLE;
        end else begin
            case (state)
                PAL_IDLE: begin
                    if (update_req) state <= PAL_ACKED;
                end
                PAL_ACKED: begin
                    if (!update_req) state <= PAL_IDLE;  // Host has seen ack
                end
                default: state <= PAL_IDLE;
            endcase
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (wr_en) begin
            colour_mem[wr_idx] <= wr_rgb;
        end
        rgb <= colour_mem[palette_idx];
    end

    assign update_ack = (state == PAL_ACKED);

    a_ack_follows_req: assert property (
        @(posedge I_vga_clk) disable iff (rst)
        $rose(update_ack) |-> $past(update_req)
    ) else $error("vga_palette ack raised without a request");

endmodule

// ==== verilog/vga.sv ====
module vga #(
    parameter vga_pkg::coord_t LAST_VISIBLE_COL = 10'd639,
    parameter vga_pkg::coord_t H_PULSE_START    = 10'd656,
    parameter vga_pkg::coord_t H_PULSE_END      = 10'd751,
    parameter vga_pkg::coord_t LAST_COL         = 10'd799,
    parameter vga_pkg::coord_t LAST_VISIBLE_ROW = 10'd479,
    parameter vga_pkg::coord_t V_PULSE_START    = 10'd490,
    parameter vga_pkg::coord_t V_PULSE_END      = 10'd491,
    parameter vga_pkg::coord_t LAST_ROW         = 10'd524
) (
    input  logic                     I_vga_clk,
    input  logic                     rst,
    input  vga_pkg::vga_mode_t       mode,
    input  vga_pkg::ram_dat_t        ram_dat,
    input  vga_pkg::ram_adr_t        base_adr,
    input  logic                     palette_update_req,
    input  vga_pkg::palette_update_t palette_update,
    output logic                     ram_req,
    output vga_pkg::ram_adr_t        ram_adr,
    output logic                     palette_update_ack,
    output logic                     hsync,
    output logic                     vsync,
    output vga_pkg::rgb_t            rgb
);

    vga_pkg::vga_mode_t    mode_q;
    logic                  test_sel, doubled;
    vga_pkg::coord_t       row, col;
    logic                  sync_h, sync_v, sync_vis;
    vga_pkg::palette_idx_t test_idx, bmp_idx, pipe_idx;
    logic                  test_h, test_v, test_vis;
    logic                  bmp_h, bmp_v, bmp_vis, bmp_req;
    logic                  pipe_h, pipe_v, pipe_vis;
    logic                  visible_q;
    vga_pkg::rgb_t         palette_rgb;

    always_ff @(posedge I_vga_clk) begin
        if (rst) mode_q <= vga_pkg::MODE_TEST;
        else     mode_q <= mode;
    end

    assign test_sel = mode_q[1];  // Unlisted value 3 falls back to the test pattern
    assign doubled  = (mode_q == vga_pkg::MODE_BITMAP_DOUBLED);

    vga_sync #(
        .LAST_VISIBLE_COL(LAST_VISIBLE_COL), .H_PULSE_START(H_PULSE_START),
        .H_PULSE_END(H_PULSE_END), .LAST_COL(LAST_COL),
        .LAST_VISIBLE_ROW(LAST_VISIBLE_ROW), .V_PULSE_START(V_PULSE_START),
        .V_PULSE_END(V_PULSE_END), .LAST_ROW(LAST_ROW)
    ) vga_sync_inst (
        .I_vga_clk(I_vga_clk), .rst(rst), .row(row), .col(col),
        .hsync(sync_h), .vsync(sync_v), .visible(sync_vis)
    );

    vga_pixelpipe_test vga_pixelpipe_test_inst (
        .I_vga_clk(I_vga_clk), .rst(rst), .row(row), .col(col),
        .hsync(sync_h), .vsync(sync_v), .visible(sync_vis),
        .palette_idx(test_idx), .hsync_out(test_h), .vsync_out(test_v),
        .visible_out(test_vis)
    );

    vga_pixelpipe_bitmap #(
        .LAST_VISIBLE_COL(LAST_VISIBLE_COL)
    ) vga_pixelpipe_bitmap_inst (
        .I_vga_clk(I_vga_clk), .rst(rst), .row(row), .col(col),
        .hsync(sync_h), .vsync(sync_v), .visible(sync_vis),
        .base_adr(base_adr), .pixel_doubled(doubled), .ram_dat(ram_dat),
        .ram_req(bmp_req), .ram_adr(ram_adr), .palette_idx(bmp_idx),
        .hsync_out(bmp_h), .vsync_out(bmp_v), .visible_out(bmp_vis)
    );

    assign pipe_idx = test_sel ? test_idx : bmp_idx;
    assign pipe_h   = test_sel ? test_h : bmp_h;
    assign pipe_v   = test_sel ? test_v : bmp_v;
    assign pipe_vis = test_sel ? test_vis : bmp_vis;
    assign ram_req  = bmp_req && !test_sel;  // No RAM traffic in test mode

    vga_palette vga_palette_inst (
        .I_vga_clk(I_vga_clk), .rst(rst), .update_req(palette_update_req),
        .update(palette_update), .palette_idx(pipe_idx),
        .update_ack(palette_update_ack), .rgb(palette_rgb)
    );

    // Matches the one cycle of palette lookup
    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            visible_q <= 1'b0;
        end else begin
            hsync     <= pipe_h;
            vsync     <= pipe_v;
            visible_q <= pipe_vis;
        end
    end

    assign rgb = visible_q ? palette_rgb : '0;

endmodule

// ==== tb/vga_tb.sv ====
module vga_tb;

    localparam vga_pkg::coord_t LAST_VISIBLE_COL = 10'd15;
    localparam vga_pkg::coord_t H_PULSE_START    = 10'd18;
    localparam vga_pkg::coord_t H_PULSE_END      = 10'd21;
    localparam vga_pkg::coord_t LAST_COL         = 10'd23;
    localparam vga_pkg::coord_t LAST_VISIBLE_ROW = 10'd11;
    localparam vga_pkg::coord_t V_PULSE_START    = 10'd13;
    localparam vga_pkg::coord_t V_PULSE_END      = 10'd14;
    localparam vga_pkg::coord_t LAST_ROW         = 10'd15;
    localparam int TIMEOUT_CYCLES = 4000;  // Covers 256 updates of 4 cycles and 6 frames of 384

    logic                     I_vga_clk = 1'b0;
    logic                     rst, palette_update_req, ram_req, palette_update_ack;
    logic                     hsync, vsync, exp_hsync, exp_vsync;
    vga_pkg::vga_mode_t       mode;
    vga_pkg::ram_dat_t        ram_dat;
    vga_pkg::ram_adr_t        base_adr, ram_adr, exp_adr;
    vga_pkg::palette_update_t palette_update;
    vga_pkg::rgb_t            rgb, exp_rgb;
    vga_pkg::ram_dat_t        ram [1024];
    vga_pkg::coord_t          trk_col, trk_row, cur_col, cur_row, req_col, req_row;
    logic                     hs_prev, vs_prev, h_lock, v_lock, check_en;
    int                       cycles = 0;
    integer                   seed = 32'h27a1_7c57;

    vga #(
        .LAST_VISIBLE_COL(LAST_VISIBLE_COL), .H_PULSE_START(H_PULSE_START),
        .H_PULSE_END(H_PULSE_END), .LAST_COL(LAST_COL),
        .LAST_VISIBLE_ROW(LAST_VISIBLE_ROW), .V_PULSE_START(V_PULSE_START),
        .V_PULSE_END(V_PULSE_END), .LAST_ROW(LAST_ROW)
    ) vga_inst (
        .I_vga_clk(I_vga_clk), .rst(rst), .mode(mode), .ram_dat(ram_dat),
        .base_adr(base_adr), .palette_update_req(palette_update_req),
        .palette_update(palette_update), .ram_req(ram_req), .ram_adr(ram_adr),
        .palette_update_ack(palette_update_ack), .hsync(hsync), .vsync(vsync), .rgb(rgb)
    );

    always #50 I_vga_clk = !I_vga_clk;

    function automatic vga_pkg::rgb_t colour_of(input vga_pkg::palette_idx_t idx);
        return {idx, idx ^ 8'h5a, ~idx};
    endfunction

    function automatic vga_pkg::ram_adr_t word_address(input vga_pkg::vga_mode_t m,
                                                      input vga_pkg::coord_t r, c);
        vga_pkg::ram_adr_t per_line;
        per_line = (LAST_VISIBLE_COL + 1) / 2;
        if (m == vga_pkg::MODE_BITMAP_DOUBLED) begin
            per_line = per_line / 2;  // Half as many pixels per line when doubled
            r = r >> 1;
            c = c >> 1;
        end
        return base_adr + vga_pkg::ram_adr_t'(r) * per_line + vga_pkg::ram_adr_t'(c >> 1);
    endfunction

    function automatic vga_pkg::palette_idx_t pixel_index(input vga_pkg::vga_mode_t m,
                                                         input vga_pkg::coord_t r, c);
        vga_pkg::ram_adr_t adr;
        vga_pkg::coord_t   bars;
        vga_pkg::ram_dat_t word;
        bars = (c ^ r) << 4;
        if (m != vga_pkg::MODE_BITMAP && m != vga_pkg::MODE_BITMAP_DOUBLED) return bars[7:0];
        adr  = word_address(m, r, c);
        word = ram[adr[9:0]];
        if (m == vga_pkg::MODE_BITMAP_DOUBLED) c = c >> 1;
        return c[0] ? word[15:8] : word[7:0];  // Low byte holds the even pixel
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected, got);
        stop_with_error($sformatf("MISMATCH at time %0t: %s expected %0h got %0h",
                                  $time, name, expected, got));
    endtask

    task automatic load_palette_entry(input vga_pkg::palette_idx_t idx);
        palette_update_req <= 1'b1;
        palette_update     <= {idx, colour_of(idx)};
        do @(posedge I_vga_clk); while (!palette_update_ack);
        palette_update_req <= 1'b0;
        do @(posedge I_vga_clk); while (palette_update_ack);
    endtask

    task automatic wait_vsync_fall();
        do @(posedge I_vga_clk); while (!(vs_prev && !vsync));
    endtask

    // Called right at a vsync fall so the new mode starts inside vertical sync
    task automatic run_two_frames(input vga_pkg::vga_mode_t m);
        mode     <= m;
        check_en <= 1'b1;
        repeat (2) wait_vsync_fall();
    endtask

    always @(posedge I_vga_clk) begin
        if (ram_req) ram_dat <= ram[ram_adr[9:0]];  // Data one clock after the request edge
    end

    // Output position follows on from the first rising edge of each sync pulse
    always_comb begin
        cur_col = (trk_col == LAST_COL) ? '0 : trk_col + 10'd1;
        cur_row = trk_row;
        if (cur_col == '0) cur_row = (trk_row == LAST_ROW) ? '0 : trk_row + 10'd1;
        if (!h_lock && hsync && !hs_prev) cur_col = H_PULSE_END + 10'd1;
        if (!v_lock && vsync && !vs_prev) cur_row = V_PULSE_END + 10'd1;
        req_col = cur_col + 10'd3;  // ram_req runs three cycles ahead of rgb
        req_row = cur_row;
        if (req_col > LAST_COL) begin
            req_col = req_col - LAST_COL - 10'd1;
            req_row = (cur_row == LAST_ROW) ? '0 : cur_row + 10'd1;
        end
        exp_hsync = !(cur_col >= H_PULSE_START && cur_col <= H_PULSE_END);
        exp_vsync = !(cur_row >= V_PULSE_START && cur_row <= V_PULSE_END);
        exp_adr   = word_address(mode, req_row, req_col);
        exp_rgb   = '0;
        if (cur_col <= LAST_VISIBLE_COL && cur_row <= LAST_VISIBLE_ROW) begin
            exp_rgb = colour_of(pixel_index(mode, cur_row, cur_col));
        end
    end

    always @(posedge I_vga_clk) begin
        if (rst) begin
            h_lock  <= 1'b0;
            v_lock  <= 1'b0;
            hs_prev <= 1'b1;
            vs_prev <= 1'b1;
        end else begin
            trk_col <= cur_col;
            trk_row <= cur_row;
            hs_prev <= hsync;
            vs_prev <= vsync;
            if (hsync && !hs_prev) h_lock <= 1'b1;
            if (vsync && !vs_prev) v_lock <= 1'b1;
        end
    end

    always @(posedge I_vga_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_error("Timeout after 4000 cycles before the mode sequence finished");
        end
    end

    a_ack_rise: assert property (@(posedge I_vga_clk) disable iff (rst)
        $rose(palette_update_req) |-> !palette_update_ack ##1 palette_update_ack)
        else stop_with_error("palette_update_ack did not rise one cycle after the request");
    a_ack_fall: assert property (@(posedge I_vga_clk) disable iff (rst)
        $fell(palette_update_req) |-> palette_update_ack ##1 !palette_update_ack)
        else stop_with_error("palette_update_ack did not fall one cycle after the request");
    a_ack_needs_req: assert property (@(posedge I_vga_clk) disable iff (rst)
        $rose(palette_update_ack) |-> $past(palette_update_req))
        else stop_with_error("palette_update_ack rose without a request");
    a_sync_idle: assert property (@(posedge I_vga_clk)
        cycles >= 1 && cycles < 20 |-> hsync && vsync)
        else stop_with_error("hsync or vsync went low right after reset");
    a_hsync: assert property (@(posedge I_vga_clk) disable iff (rst) h_lock |-> hsync == exp_hsync)
        else report_mismatch("hsync", $sampled(exp_hsync), $sampled(hsync));
    a_vsync: assert property (@(posedge I_vga_clk) disable iff (rst) v_lock |-> vsync == exp_vsync)
        else report_mismatch("vsync", $sampled(exp_vsync), $sampled(vsync));
    a_rgb: assert property (@(posedge I_vga_clk) disable iff (rst)
        check_en && h_lock && v_lock |-> rgb == exp_rgb)
        else report_mismatch("rgb", $sampled(exp_rgb), $sampled(rgb));
    a_ram_adr: assert property (@(posedge I_vga_clk) disable iff (rst)
        check_en && h_lock && v_lock && ram_req |-> ram_adr == exp_adr)
        else report_mismatch("ram_adr", $sampled(exp_adr), $sampled(ram_adr));
    a_no_req_in_test: assert property (@(posedge I_vga_clk) disable iff (rst)
        mode == vga_pkg::MODE_TEST |-> !ram_req)
        else stop_with_error("ram_req went high in test mode");

    initial begin
        rst                = 1'b1;
        mode               = vga_pkg::MODE_TEST;
        ram_dat            = '0;
        base_adr           = 18'h00140;
        palette_update_req = 1'b0;
        palette_update     = '0;
        check_en           = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            ram[i] = vga_pkg::ram_dat_t'($random(seed));
        end
        repeat (3) @(posedge I_vga_clk);
        rst <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            load_palette_entry(vga_pkg::palette_idx_t'(i));
        end
        wait_vsync_fall();
        run_two_frames(vga_pkg::MODE_TEST);
        run_two_frames(vga_pkg::MODE_BITMAP);
        run_two_frames(vga_pkg::MODE_BITMAP_DOUBLED);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/vga_pkg.sv
verilog/vga_sync.sv
verilog/vga_pixelpipe_test.sv
verilog/vga_pixelpipe_bitmap.sv
verilog/vga_palette.sv
verilog/vga.sv
tb/vga_tb.sv

// ==== Bender.yml ====
package:
  name: vga

sources:
  - verilog/vga_pkg.sv
  - verilog/vga_sync.sv
  - verilog/vga_pixelpipe_test.sv
  - verilog/vga_pixelpipe_bitmap.sv
  - verilog/vga_palette.sv
  - verilog/vga.sv
  - target: test
    files:
      - tb/vga_tb.sv
